/* Makefile */
# Verilator simulation of the rv32i subset core; variables can be overridden on the command line.
TOP       ?= tb_cpu_top
SEED      ?= 1
LOG       ?= sim.log
BUILD     ?= obj_dir
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f flist.f --top-module $(TOP) --Mdir $(BUILD) -o V$(TOP)
	./$(BUILD)/V$(TOP) +verilator+seed+$(SEED) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^No errors$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

/* alu_execute.sv */
// execute stage, alu and branch resolution, registered for writeback.
`timescale 1ns/1ps

module alu_execute import rv_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_i,
    input  logic     dec_valid_i,
    input  alu_op_e  dec_op_i,
    input  br_kind_e dec_br_i,
    input  reg_idx_t dec_rd_i,
    input  xlen_t    dec_imm_i,
    input  logic     dec_use_imm_i,
    input  xlen_t    dec_pc_i,
    input  xlen_t    rs1_data_i,
    input  xlen_t    rs2_data_i,
    output logic     ex_valid_o,
    output reg_idx_t ex_rd_o,
    output xlen_t    ex_data_o,
    output xlen_t    ex_pc_o,
    output logic     redirect_valid_o,
    output xlen_t    redirect_pc_o
);

    xlen_t opb;
    xlen_t result;
    logic  is_cond;
    logic  taken;

    assign opb     = dec_use_imm_i ? dec_imm_i : rs2_data_i;
    assign is_cond = (dec_br_i == BR_BEQ) || (dec_br_i == BR_BNE);

    always_comb begin
        case (dec_op_i)
            ALU_SUB:    result = rs1_data_i - opb;
            ALU_AND:    result = rs1_data_i & opb;
            ALU_OR:     result = rs1_data_i | opb;
            ALU_XOR:    result = rs1_data_i ^ opb;
            ALU_SLT:    result = {31'b0, $signed(rs1_data_i) < $signed(opb)};
            ALU_PASS_B: result = opb;
            ALU_LINK:   result = dec_pc_i + 32'd4;
            default:    result = rs1_data_i + opb;
        endcase
    end

    always_comb begin
        case (dec_br_i)
            BR_BEQ:  taken = (rs1_data_i == rs2_data_i);
            BR_BNE:  taken = (rs1_data_i != rs2_data_i);
            BR_JAL:  taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ex_valid_o       <= 1'b0;
            redirect_valid_o <= 1'b0;
        end else begin
            ex_valid_o       <= dec_valid_i;
            redirect_valid_o <= dec_valid_i && taken;
        end
    end

    // conditional branches retire as a write of 0 to x0.
    always_ff @(posedge clk_i) begin
        if (dec_valid_i) begin
            ex_rd_o       <= is_cond ? '0 : dec_rd_i;
            ex_data_o     <= is_cond ? '0 : result;
            ex_pc_o       <= dec_pc_i;
            redirect_pc_o <= dec_pc_i + dec_imm_i;
        end
    end

endmodule

/* cpu_top.sv */
// top level of the rv32i subset core, connects fetch, cache, decode, execute and writeback.
`timescale 1ns/1ps

module cpu_top import rv_pkg::*; #(
    parameter int    ICACHE_LINES = 64,
    parameter xlen_t RESET_PC = '0
) (
    input  logic     clk_i,
    input  logic     rst_i,
    output logic     imem_valid_o,
    output xlen_t    imem_addr_o,
    input  logic     imem_ready_i,
    input  xlen_t    imem_rdata_i,
    output logic     retire_valid_o,
    output reg_idx_t retire_rd_o,
    output xlen_t    retire_data_o,
    output xlen_t    retire_pc_o
);

    logic     fetch_req, fetch_stall;
    xlen_t    fetch_pc, fetch_instr;
    logic     instr_valid;
    xlen_t    instr, instr_pc;
    logic     dec_valid, dec_use_imm;
    alu_op_e  dec_op;
    br_kind_e dec_br;
    reg_idx_t dec_rs1, dec_rs2, dec_rd;
    xlen_t    dec_imm, dec_pc;
    xlen_t    rs1_data, rs2_data;
    logic     ex_valid, redirect_valid;
    reg_idx_t ex_rd;
    xlen_t    ex_data, ex_pc, redirect_pc;

    fetch_sequencer #(.RESET_PC(RESET_PC)) i_fetch (
        .clk_i, .rst_i,
        .fetch_req_o(fetch_req), .fetch_pc_o(fetch_pc),
        .fetch_stall_i(fetch_stall), .fetch_instr_i(fetch_instr),
        .instr_valid_o(instr_valid), .instr_o(instr), .instr_pc_o(instr_pc),
        .redirect_valid_i(redirect_valid), .redirect_pc_i(redirect_pc),
        .retire_valid_i(retire_valid_o)
    );

    icache #(.ICACHE_LINES(ICACHE_LINES)) i_icache (
        .clk_i, .rst_i,
        .fetch_req_i(fetch_req), .fetch_pc_i(fetch_pc),
        .fetch_stall_o(fetch_stall), .fetch_instr_o(fetch_instr),
        .imem_valid_o, .imem_addr_o, .imem_ready_i, .imem_rdata_i
    );

    instr_decode i_decode (
        .clk_i, .rst_i,
        .instr_valid_i(instr_valid), .instr_i(instr), .instr_pc_i(instr_pc),
        .dec_valid_o(dec_valid), .dec_op_o(dec_op), .dec_br_o(dec_br),
        .dec_rs1_o(dec_rs1), .dec_rs2_o(dec_rs2), .dec_rd_o(dec_rd),
        .dec_imm_o(dec_imm), .dec_use_imm_o(dec_use_imm), .dec_pc_o(dec_pc)
    );

    alu_execute i_execute (
        .clk_i, .rst_i,
        .dec_valid_i(dec_valid), .dec_op_i(dec_op), .dec_br_i(dec_br),
        .dec_rd_i(dec_rd), .dec_imm_i(dec_imm), .dec_use_imm_i(dec_use_imm),
        .dec_pc_i(dec_pc), .rs1_data_i(rs1_data), .rs2_data_i(rs2_data),
        .ex_valid_o(ex_valid), .ex_rd_o(ex_rd), .ex_data_o(ex_data), .ex_pc_o(ex_pc),
        .redirect_valid_o(redirect_valid), .redirect_pc_o(redirect_pc)
    );

    result_writeback i_writeback (
        .clk_i, .rst_i,
        .ex_valid_i(ex_valid), .ex_rd_i(ex_rd), .ex_data_i(ex_data), .ex_pc_i(ex_pc),
        .rs1_idx_i(dec_rs1), .rs2_idx_i(dec_rs2),
        .rs1_data_o(rs1_data), .rs2_data_o(rs2_data),
        .retire_valid_o, .retire_rd_o, .retire_data_o, .retire_pc_o
    );

endmodule

/* fetch_sequencer.sv */
// program counter and fetch/retire phase control that cpu_top instantiates for the core.
`timescale 1ns/1ps

module fetch_sequencer import rv_pkg::*; #(
    parameter xlen_t RESET_PC = '0
) (
    input  logic  clk_i,
    input  logic  rst_i,
    output logic  fetch_req_o,
    output xlen_t fetch_pc_o,
    input  logic  fetch_stall_i,
    input  xlen_t fetch_instr_i,
    output logic  instr_valid_o,
    output xlen_t instr_o,
    output xlen_t instr_pc_o,
    input  logic  redirect_valid_i,
    input  xlen_t redirect_pc_i,
    input  logic  retire_valid_i
);

    typedef enum logic {
        PH_FETCH,
        PH_WAIT
    } phase_e;

    phase_e phase_q;
    xlen_t  pc_q;
    logic   req_q;
    logic   redir_pend_q;
    xlen_t  redir_pc_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            phase_q      <= PH_FETCH;
            pc_q         <= RESET_PC;
            req_q        <= 1'b0;
            redir_pend_q <= 1'b0;
        end else begin
            case (phase_q)
                PH_FETCH: begin
                    if (req_q && !fetch_stall_i) begin
                        phase_q <= PH_WAIT;
                        req_q   <= 1'b0;
                    end else begin
                        req_q <= 1'b1;
                    end
                end
                default: begin
                    // redirect arrives one cycle ahead of retire.
                    if (redirect_valid_i) begin
                        redir_pend_q <= 1'b1;
                        redir_pc_q   <= redirect_pc_i;
                    end
                    if (retire_valid_i) begin
                        phase_q      <= PH_FETCH;
                        req_q        <= 1'b1;
                        redir_pend_q <= 1'b0;
                        pc_q         <= redir_pend_q ? redir_pc_q : pc_q + 32'd4;
                    end
                end
            endcase
        end
    end

    assign fetch_req_o   = req_q;
    assign fetch_pc_o    = pc_q;
    assign instr_valid_o = req_q && !fetch_stall_i;
    assign instr_o       = fetch_instr_i;
    assign instr_pc_o    = pc_q;

    // redirect and retire only come back for the instruction in flight.
    a_return_in_wait: assert property (@(posedge clk_i) disable iff (rst_i)
        redirect_valid_i || retire_valid_i |-> phase_q == PH_WAIT);

endmodule

/* flist.f */
+incdir+.
rv_pkg.sv
icache.sv
fetch_sequencer.sv
instr_decode.sv
alu_execute.sv
result_writeback.sv
cpu_top.sv
tb_cpu_top.sv

/* icache.sv */
// direct-mapped instruction cache that cpu_top places between the fetch sequencer and the imem port.
`timescale 1ns/1ps

module icache import rv_pkg::*; #(
    parameter int ICACHE_LINES = 64
) (
    input  logic  clk_i,
    input  logic  rst_i,
    input  logic  fetch_req_i,
    input  xlen_t fetch_pc_i,
    output logic  fetch_stall_o,
    output xlen_t fetch_instr_o,
    output logic  imem_valid_o,
    output xlen_t imem_addr_o,
    input  logic  imem_ready_i,
    input  xlen_t imem_rdata_i
);

    localparam int IDX_W = $clog2(ICACHE_LINES);
    localparam int TAG_W = IADDR_W - IDX_W - 2;

    cache_state_e state_q;
    cache_state_e state_d;
    logic [IDX_W:0] sweep_cnt_q;

    logic [ICACHE_LINES-1:0] line_valid_q;
    logic [TAG_W-1:0] line_tag_q [ICACHE_LINES];
    xlen_t line_data_q [ICACHE_LINES];

    logic [IDX_W-1:0] idx;
    logic [TAG_W-1:0] tag;
    logic hit;

    assign idx = fetch_pc_i[IDX_W+1:2];
    assign tag = fetch_pc_i[IADDR_W-1:IDX_W+2];
    assign hit = line_valid_q[idx] && (line_tag_q[idx] == tag);

    always_comb begin
        state_d = state_q;
        case (state_q)
            CS_SWEEP: begin
                if (sweep_cnt_q == ICACHE_LINES[IDX_W:0]) state_d = CS_IDLE;
            end
            CS_IDLE: begin
                if (fetch_req_i && !hit) state_d = CS_REFILL;
            end
            CS_REFILL: begin
                if (imem_ready_i) state_d = CS_IDLE;
            end
            default: state_d = CS_SWEEP;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q     <= CS_SWEEP;
            sweep_cnt_q <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == CS_SWEEP) sweep_cnt_q <= sweep_cnt_q + 1'b1;
        end
    end

    // the sweep clears one valid bit per cycle.
    always_ff @(posedge clk_i) begin
        if (state_q == CS_SWEEP && !sweep_cnt_q[IDX_W]) begin
            line_valid_q[sweep_cnt_q[IDX_W-1:0]] <= 1'b0;
        end else if (state_q == CS_REFILL && imem_ready_i) begin
            line_valid_q[idx] <= 1'b1;
            line_tag_q[idx]   <= tag;
            line_data_q[idx]  <= imem_rdata_i;
        end
    end

    assign fetch_instr_o = line_data_q[idx];
    assign fetch_stall_o = (state_q != CS_IDLE) || (fetch_req_i && !hit);
    assign imem_valid_o  = (state_q == CS_REFILL);
    assign imem_addr_o   = fetch_pc_i;

    // every line is invalid once the sweep hands over to idle.
    a_sweep_clears: assert property (@(posedge clk_i) disable iff (rst_i)
        state_q == CS_SWEEP && state_d == CS_IDLE |=> line_valid_q == '0);

    // the sequencer must hold the pc while the refill is pending.
    a_addr_stable: assert property (@(posedge clk_i) disable iff (rst_i)
        imem_valid_o && !imem_ready_i |=> $stable(imem_addr_o));

endmodule

/* instr_decode.sv */
// decode stage, splits the instruction word and registers the fields for execute.
`timescale 1ns/1ps

module instr_decode import rv_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_i,
    input  logic     instr_valid_i,
    input  xlen_t    instr_i,
    input  xlen_t    instr_pc_i,
    output logic     dec_valid_o,
    output alu_op_e  dec_op_o,
    output br_kind_e dec_br_o,
    output reg_idx_t dec_rs1_o,
    output reg_idx_t dec_rs2_o,
    output reg_idx_t dec_rd_o,
    output xlen_t    dec_imm_o,
    output logic     dec_use_imm_o,
    output xlen_t    dec_pc_o
);

    logic [2:0] funct3;
    logic       sub_bit;
    xlen_t      imm_i, imm_u, imm_b, imm_j;

    alu_op_e  op_d;
    br_kind_e br_d;
    reg_idx_t rd_d;
    xlen_t    imm_d;
    logic     use_imm_d;

    assign funct3  = instr_i[14:12];
    assign sub_bit = instr_i[30];
    assign imm_i   = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_u   = {instr_i[31:12], 12'b0};
    assign imm_b   = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
    assign imm_j   = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};

    always_comb begin
        // anything unsupported falls back to addi x0, x?, 0.
        op_d      = ALU_ADD;
        br_d      = BR_NONE;
        rd_d      = '0;
        imm_d     = '0;
        use_imm_d = 1'b1;
        case (opcode_e'(instr_i[6:0]))
            OPC_OP: begin
                use_imm_d = 1'b0;
                rd_d      = instr_i[11:7];
                case (funct3)
                    3'b000:  op_d = sub_bit ? ALU_SUB : ALU_ADD;
                    3'b010:  op_d = ALU_SLT;
                    3'b100:  op_d = ALU_XOR;
                    3'b110:  op_d = ALU_OR;
                    3'b111:  op_d = ALU_AND;
                    default: rd_d = '0;
                endcase
            end
            OPC_OP_IMM: begin
                rd_d  = instr_i[11:7];
                imm_d = imm_i;
                case (funct3)
                    3'b000:  op_d = ALU_ADD;
                    3'b100:  op_d = ALU_XOR;
                    3'b110:  op_d = ALU_OR;
                    3'b111:  op_d = ALU_AND;
                    default: rd_d = '0;
                endcase
            end
            OPC_LUI: begin
                op_d  = ALU_PASS_B;
                rd_d  = instr_i[11:7];
                imm_d = imm_u;
            end
            OPC_BRANCH: begin
                use_imm_d = 1'b0;
                imm_d     = imm_b;
                if (funct3 == 3'b000) br_d = BR_BEQ;
                else if (funct3 == 3'b001) br_d = BR_BNE;
            end
            OPC_JAL: begin
                op_d  = ALU_LINK;
                br_d  = BR_JAL;
                rd_d  = instr_i[11:7];
                imm_d = imm_j;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) dec_valid_o <= 1'b0;
        else       dec_valid_o <= instr_valid_i;
    end

    always_ff @(posedge clk_i) begin
        if (instr_valid_i) begin
            dec_op_o      <= op_d;
            dec_br_o      <= br_d;
            dec_rs1_o     <= instr_i[19:15];
            dec_rs2_o     <= instr_i[24:20];
            dec_rd_o      <= rd_d;
            dec_imm_o     <= imm_d;
            dec_use_imm_o <= use_imm_d;
            dec_pc_o      <= instr_pc_i;
        end
    end

endmodule

/* result_writeback.sv */
// register file with the result write and the retire report.
`timescale 1ns/1ps

module result_writeback import rv_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_i,
    input  logic     ex_valid_i,
    input  reg_idx_t ex_rd_i,
    input  xlen_t    ex_data_i,
    input  xlen_t    ex_pc_i,
    input  reg_idx_t rs1_idx_i,
    input  reg_idx_t rs2_idx_i,
    output xlen_t    rs1_data_o,
    output xlen_t    rs2_data_o,
    output logic     retire_valid_o,
    output reg_idx_t retire_rd_o,
    output xlen_t    retire_data_o,
    output xlen_t    retire_pc_o
);

    // x1..x31, x0 is hardwired.
    xlen_t regs_q [1:31];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 1; i < 32; i++) regs_q[i] <= '0;
        end else if (ex_valid_i && ex_rd_i != '0) begin
            regs_q[ex_rd_i] <= ex_data_i;
        end
    end

    always_comb begin
        rs1_data_o = '0;
        rs2_data_o = '0;
        if (rs1_idx_i != '0) rs1_data_o = regs_q[rs1_idx_i];
        if (rs2_idx_i != '0) rs2_data_o = regs_q[rs2_idx_i];
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) retire_valid_o <= 1'b0;
        else       retire_valid_o <= ex_valid_i;
    end

    always_ff @(posedge clk_i) begin
        if (ex_valid_i) begin
            retire_rd_o   <= ex_rd_i;
            retire_data_o <= (ex_rd_i == '0) ? '0 : ex_data_i;
            retire_pc_o   <= ex_pc_i;
        end
    end

endmodule

/* rv_pkg.sv */
// shared types for the rv32i subset core, imported by every rtl module.
package rv_pkg;

    localparam int XLEN = 32;
    localparam int REG_IDX_W = 5;
    // instruction address space seen by the cache.
    localparam int IADDR_W = 16;

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    // major opcodes, bits 6:0 of the instruction word.
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_AND    = 4'd2,
        ALU_OR     = 4'd3,
        ALU_XOR    = 4'd4,
        ALU_SLT    = 4'd5,
        ALU_PASS_B = 4'd6,
        ALU_LINK   = 4'd7
    } alu_op_e;

    typedef enum logic [1:0] {
        BR_NONE = 2'd0,
        BR_BEQ  = 2'd1,
        BR_BNE  = 2'd2,
        BR_JAL  = 2'd3
    } br_kind_e;

    // instruction cache controller states.
    typedef enum logic [1:0] {
        CS_SWEEP  = 2'd0,
        CS_IDLE   = 2'd1,
        CS_REFILL = 2'd2
    } cache_state_e;

endpackage

/* tb_ref_model.svh */
// program generator and instruction-set model for the core testbench, included in tb_cpu_top.
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// funct3 per generated operation: add sub and or xor slt addi andi ori xori.
localparam logic [2:0] F3_OF [10] = '{3'd0, 3'd0, 3'd7, 3'd6, 3'd4, 3'd2, 3'd0, 3'd7, 3'd6, 3'd4};

function automatic xlen_t enc_ri(logic [11:0] hi, reg_idx_t rs1, logic [2:0] f3, reg_idx_t rd,
                                 opcode_e opc);
    return {hi, rs1, f3, rd, opc};
endfunction

function automatic xlen_t enc_b(int off, reg_idx_t rs1, reg_idx_t rs2, logic [2:0] f3);
    logic [12:0] o;
    o = off[12:0];
    return {o[12], o[10:5], rs2, rs1, f3, o[4:1], o[11], OPC_BRANCH};
endfunction

function automatic xlen_t enc_j(int off, reg_idx_t rd);
    logic [20:0] o;
    o = off[20:0];
    return {o[20], o[10:1], o[11], o[19:12], rd, OPC_JAL};
endfunction

// x0 to x15, never x1 which holds the loop count.
function automatic reg_idx_t rand_reg();
    logic [31:0] r;
    r = $random(seed);
    return (r[3:0] == 4'd1) ? 5'd0 : {1'b0, r[3:0]};
endfunction

function automatic bit unreachable(xlen_t addr);
    return addr > jal_pc && addr < halt_pc;
endfunction

// counted bne loop around a random body, then a jal over SKIP words to a self-loop.
task automatic gen_program(input int body_len, input int loops);
    logic [31:0] r;
    logic [31:0] s;
    reg_idx_t rd;
    reg_idx_t rs1;
    reg_idx_t rs2;
    int sel;
    int a;
    for (int i = 0; i < 16384; i++) mem[i] = {2'b10, i[13:0], 2'b01, i[13:0]};
    mem[0] = enc_ri(loops[11:0], 5'd0, 3'd0, 5'd1, OPC_OP_IMM);
    for (a = 1; a <= body_len; a++) begin
        r = $random(seed);
        s = $random(seed);
        rd = rand_reg();
        rs1 = rand_reg();
        rs2 = rand_reg();
        sel = int'(s[15:0]) % 11;
        if (sel < 6) begin
            mem[a] = enc_ri({(sel == 1) ? 7'h20 : 7'h00, rs2}, rs1, F3_OF[sel], rd, OPC_OP);
        end else if (sel < 10) begin
            mem[a] = enc_ri(r[11:0], rs1, F3_OF[sel], rd, OPC_OP_IMM);
        end else begin
            mem[a] = {r[31:12], rd, OPC_LUI};
        end
    end
    mem[a] = enc_ri(12'hfff, 5'd1, 3'd0, 5'd1, OPC_OP_IMM);
    mem[a + 1] = enc_b(-4 * a, 5'd1, 5'd0, 3'd1);
    jal_pc = (a + 2) * 4;
    mem[a + 2] = enc_j((SKIP + 1) * 4, rand_reg());
    halt_pc = jal_pc + (SKIP + 1) * 4;
    mem[halt_pc[15:2]] = enc_j(0, 5'd0);
endtask

// steps the program from pc 0 to the self-loop, with a direct-mapped cache of LINES words.
task automatic run_model();
    xlen_t regs [32];
    xlen_t pc;
    xlen_t w;
    xlen_t a;
    xlen_t b;
    xlen_t res;
    xlen_t nxt;
    reg_idx_t rd;
    int line_addr [LINES];
    int idx;
    bit hit;
    exp_pc.delete();
    exp_rd.delete();
    exp_data.delete();
    exp_hit.delete();
    exp_req.delete();
    foreach (regs[i]) regs[i] = '0;
    foreach (line_addr[i]) line_addr[i] = -1;
    pc = '0;
    for (int n = 0; n < 5000; n++) begin
        idx = int'(pc[15:2]) % LINES;
        hit = (line_addr[idx] == int'(pc[15:0]));
        if (!hit) begin
            exp_req.push_back(pc);
            line_addr[idx] = int'(pc[15:0]);
        end
        w = mem[pc[15:2]];
        rd = w[11:7];
        a = regs[w[19:15]];
        b = (w[6:0] == OPC_OP) ? regs[w[24:20]] : {{20{w[31]}}, w[31:20]};
        nxt = pc + 32'd4;
        case (w[14:12])
            3'd0: res = (w[6:0] == OPC_OP && w[30]) ? a - b : a + b;
            3'd2: res = {31'b0, $signed(a) < $signed(b)};
            3'd4: res = a ^ b;
            3'd6: res = a | b;
            default: res = a & b;
        endcase
        if (w[6:0] == OPC_LUI) res = {w[31:12], 12'b0};
        if (w[6:0] == OPC_JAL) begin
            res = nxt;
            nxt = pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        end
        if (w[6:0] == OPC_BRANCH) begin
            rd = '0;
            // beq when funct3 bit 0 is clear, bne when set.
            if ((a != regs[w[24:20]]) == w[12]) begin
                nxt = pc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            end
        end
        if (rd == '0) res = '0;
        else regs[rd] = res;
        exp_pc.push_back(pc);
        exp_rd.push_back(rd);
        exp_data.push_back(res);
        exp_hit.push_back(hit);
        if (pc == halt_pc) break;
        pc = nxt;
    end
    exp_len = exp_pc.size();
endtask

`endif

/* tb_cpu_top.sv */
// testbench for cpu_top, runs random loop programs and checks retires and imem requests.
`timescale 1ns/1ps

module tb_cpu_top import rv_pkg::*; ();

    localparam int LINES = 16;
    localparam int SKIP = 3;

    logic     clk_i;
    logic     rst_i;
    logic     imem_valid_o;
    xlen_t    imem_addr_o;
    logic     imem_ready_i;
    xlen_t    imem_rdata_i;
    logic     retire_valid_o;
    reg_idx_t retire_rd_o;
    xlen_t    retire_data_o;
    xlen_t    retire_pc_o;

    integer   seed = 32'h5579;
    xlen_t    mem [16384];
    xlen_t    jal_pc;
    xlen_t    halt_pc;
    xlen_t    exp_pc [$];
    reg_idx_t exp_rd [$];
    xlen_t    exp_data [$];
    bit       exp_hit [$];
    xlen_t    exp_req [$];
    int       exp_len;
    int       ret_idx;
    int       req_idx;
    int       cyc;
    int       last_cyc;
    int       wd_cnt;
    int       wd_limit;
    int       errors;
    int       checks;
    int       tests;
    bit       checking;

    `include "tb_ref_model.svh"

    cpu_top #(.ICACHE_LINES(LINES), .RESET_PC(32'h0)) i_dut (.*);

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    task automatic check_retire(input xlen_t pc, input reg_idx_t rd, input xlen_t data);
        checks++;
        if (pc !== exp_pc[ret_idx]) begin
            errors++;
            $display("FAILED %0t retire_pc_o expected %h got %h", $time, exp_pc[ret_idx], pc);
        end
        if (rd !== exp_rd[ret_idx]) begin
            errors++;
            $display("FAILED %0t retire_rd_o expected %0d got %0d", $time, exp_rd[ret_idx], rd);
        end
        if (data !== exp_data[ret_idx]) begin
            errors++;
            $display("FAILED %0t retire_data_o expected %h got %h", $time, exp_data[ret_idx], data);
        end
        if (unreachable(pc)) begin
            errors++;
            $display("an instruction from the skipped block retired at pc %h", pc);
        end
    endtask

    task automatic check_addr(input xlen_t want, input xlen_t got);
        checks++;
        if (got !== want) begin
            errors++;
            $display("FAILED %0t imem_addr_o expected %h got %h", $time, want, got);
        end
    endtask

    task automatic check_cycles(input string what, input int got, input int want);
        checks++;
        if (got != want) begin
            errors++;
            $display("FAILED %0t %s expected %0d got %0d", $time, what, want, got);
        end
    endtask

    // imem responder, answers each request after 0 to 5 cycles.
    initial begin
        int delay;
        forever begin
            @(posedge clk_i);
            if (imem_valid_o === 1'b1) begin
                delay = $unsigned($random(seed)) % 6;
                if (checking && req_idx < exp_req.size()) begin
                    check_addr(exp_req[req_idx], imem_addr_o);
                end else if (checking) begin
                    errors++;
                    $display("imem request for %h when no more requests were expected", imem_addr_o);
                end
                if (checking && unreachable(imem_addr_o)) begin
                    errors++;
                    $display("imem request for the skipped word at %h", imem_addr_o);
                end
                req_idx++;
                repeat (delay) @(posedge clk_i);
                #1;
                imem_ready_i = 1'b1;
                imem_rdata_i = mem[imem_addr_o[15:2]];
                @(posedge clk_i);
                #1;
                imem_ready_i = 1'b0;
            end
        end
    end

    // retire monitor, also checks the 4-cycle spacing of hits.
    always @(posedge clk_i) begin
        cyc++;
        if (checking && retire_valid_o === 1'b1 && ret_idx < exp_len) begin
            check_retire(retire_pc_o, retire_rd_o, retire_data_o);
            if (exp_hit[ret_idx] && ret_idx > 0) begin
                check_cycles("cycles between retire_valid_o strobes", cyc - last_cyc, 4);
            end
            last_cyc = cyc;
            ret_idx++;
        end
    end

    initial begin
        while (!(checking && wd_cnt > wd_limit)) begin
            @(posedge clk_i);
            if (checking) wd_cnt++;
        end
        $display("timeout, the core hung after %0d of %0d retires", ret_idx, exp_len);
        $display("Errors found");
        $finish;
    end

    task automatic run_test(input string name, input int body_len, input int loops);
        int err0;
        int early;
        err0 = errors;
        early = 0;
        @(posedge clk_i);
        #1;
        rst_i = 1'b1;
        checking = 1'b0;
        gen_program(body_len, loops);
        run_model();
        for (int i = 0; i < 16; i++) begin
            @(posedge clk_i);
            if (i > 0 && (imem_valid_o !== 1'b0 || retire_valid_o !== 1'b0)) early++;
        end
        #1;
        rst_i = 1'b0;
        ret_idx = 0;
        req_idx = 0;
        wd_cnt = 0;
        wd_limit = exp_len * 4 + exp_req.size() * 9 + LINES + 200;
        checking = 1'b1;
        // sweep window, nothing may leave the core.
        repeat (LINES + 1) begin
            @(posedge clk_i);
            if (imem_valid_o !== 1'b0 || retire_valid_o !== 1'b0) early++;
        end
        wait (ret_idx == exp_len);
        checking = 1'b0;
        check_cycles("imem_valid_o/retire_valid_o cycles in reset and sweep", early, 0);
        check_cycles("imem request count", req_idx, exp_req.size());
        tests++;
        $display("test %s %s", name, (errors == err0) ? "passed" : "failed");
    endtask

    initial begin
        rst_i = 1'b1;
        imem_ready_i = 1'b0;
        imem_rdata_i = '0;
        run_test("loop inside cache", 6, 3);
        run_test("loop aliasing cache lines", LINES + 5, 2);
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule
